// ==== include/commit_defines.svh ====
`ifndef COMMIT_DEFINES_SVH
`define COMMIT_DEFINES_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register file and address widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define ARF_W       5               // Architectural register index.
`define PRF_W       7               // Physical register index.
`define PRF_N       128
`define ADDR_W      32
`define EXC_CODE_W  20

`define TRUE        1'b1
`define FALSE       1'b0

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Retire configuration
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define CQ_DEPTH    8               // Pairs, power of two.
`define EXC_VECTOR  32'hBFC00380    // General exception entry.

`endif

// ==== verilog/excPkg.sv ====
`include "commit_defines.svh"

package excPkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Exception kinds raised by retiring micro-ops
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [2:0] {
        excNone,
        excSyscall,
        excBreak,
        excReserved,                    // Reserved instruction.
        excOverflow,
        excAddrLoad                     // Misaligned load address.
    } ExceptionType;

    // Exception view of the 32-bit payload word.
    typedef struct packed {
        ExceptionType               kind;
        logic [`EXC_CODE_W-1:0]     code;
        logic [8:0]                 pad;
    } ExcInfo;

endpackage

// ==== verilog/uopPkg.sv ====
`include "commit_defines.svh"

package uopPkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Micro-op classification
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [1:0] {
        typeNormal,                     // Not a control transfer.
        typeBranch,
        typeJump,
        typeJumpReg
    } BranchType;

    typedef enum logic [1:0] {
        uopAlu,
        uopMem,
        uopBranch,
        uopBubble                       // Empty slot.
    } UopKind;

    // Resolved branch target, or exception info when causeExc is set.
    typedef union packed {
        logic [`ADDR_W-1:0]         branchAddr;
        excPkg::ExcInfo             exc;
    } UopPayload;

    typedef struct packed {
        logic                       valid;
        UopKind                     kind;
        logic [`ADDR_W-1:0]         pc;
        BranchType                  branchType;
        logic                       branchTaken;
        logic                       predTaken;
        logic [`ADDR_W-1:0]         predAddr;
        logic                       causeExc;
        UopPayload                  payload;
        logic                       dstwe;
        logic [`ARF_W-1:0]          dstLAddr;
        logic [`PRF_W-1:0]          dstPAddr;
        logic [`PRF_W-1:0]          dstPStale;      // Previous mapping of dstLAddr.
    } RetiredUop;

endpackage

// ==== verilog/completionQueue.sv ====
`timescale 1ns/1ns
`include "commit_defines.svh"

module completionQueue (
    input  logic                clk,
    input  logic                rst,

    input  logic                pushValid,
    input  uopPkg::RetiredUop   pushUop0,
    input  uopPkg::RetiredUop   pushUop1,

    input  logic                pop,
    input  logic                flush,

    output logic                queueFull,
    output logic                headValid,
    output uopPkg::RetiredUop   headUop0,
    output uopPkg::RetiredUop   headUop1
);

    import uopPkg::*;

    localparam int PTR_W = $clog2(`CQ_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    RetiredUop          slot0Mem [`CQ_DEPTH];
    RetiredUop          slot1Mem [`CQ_DEPTH];

    logic [PTR_W-1:0]   headPtr;
    logic [PTR_W-1:0]   tailPtr;
    logic [CNT_W-1:0]   count;
    logic               doPush;
    logic               doPop;

    assign queueFull = count == CNT_W'(`CQ_DEPTH);
    assign headValid = count != '0;

    assign doPush = pushValid && !queueFull;        // Push into a full queue is lost.
    assign doPop  = pop && headValid;

    assign headUop0 = slot0Mem[headPtr];
    assign headUop1 = slot1Mem[headPtr];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pair storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (doPush) begin
            slot0Mem[tailPtr] <= pushUop0;
            slot1Mem[tailPtr] <= pushUop1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pointers and occupancy
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            headPtr <= '0;                          // Flush drops everything queued.
            tailPtr <= '0;
            count   <= '0;
        end else begin
            if (doPush) begin
                tailPtr <= tailPtr + 1'b1;          // Wraps at CQ_DEPTH.
            end
            if (doPop) begin
                headPtr <= headPtr + 1'b1;
            end
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== verilog/commitStage.sv ====
`timescale 1ns/1ns
`include "commit_defines.svh"

module commitStage (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    headValid,
    input  uopPkg::RetiredUop       headUop0,
    input  uopPkg::RetiredUop       headUop1,
    output logic                    pop,

    output logic                    commitValid0,
    output logic                    commitValid1,
    output logic                    wrRegCommit0,
    output logic                    wrRegCommit1,
    output logic [`ARF_W-1:0]       committedArf0,
    output logic [`ARF_W-1:0]       committedArf1,
    output logic [`PRF_W-1:0]       committedPrf0,
    output logic [`PRF_W-1:0]       committedPrf1,
    output logic [`PRF_W-1:0]       stalePrf0,
    output logic [`PRF_W-1:0]       stalePrf1,

    output logic                    flush,
    output logic                    redirect,
    output logic [`ADDR_W-1:0]      redirectPc,

    output logic                    excValid,
    output excPkg::ExceptionType    excKind,
    output logic [`EXC_CODE_W-1:0]  excCode
);

    import uopPkg::*;

    logic                   isBranch0;
    logic                   takePredFail;
    logic                   addrPredFail;
    logic                   predFailNow;
    logic [`ADDR_W-1:0]     target;
    logic                   exc0;
    logic                   exc1;

    logic                   predFailed;
    logic                   waitDs;
    logic                   lastWaitDs;
    logic [`ADDR_W-1:0]     branchTarget;

    assign pop = headValid && !flush;               // No stall, retire whenever valid.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Branch resolution, slot 0 only
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign isBranch0    = headUop0.valid && headUop0.branchType != typeNormal;
    assign takePredFail = isBranch0 && headUop0.branchTaken != headUop0.predTaken;
    assign addrPredFail = isBranch0 && !takePredFail && headUop0.branchTaken
                          && headUop0.payload.branchAddr != headUop0.predAddr;

    // A branch sitting in the delay slot of a pending wait is not resolved here.
    assign predFailNow  = pop && (takePredFail || addrPredFail) && !waitDs;

    assign target = headUop0.branchTaken ? headUop0.payload.branchAddr
                                         : headUop0.pc + `ADDR_W'(8);

    assign exc0 = headUop0.valid && headUop0.causeExc;
    assign exc1 = headUop1.valid && headUop1.causeExc;

    always_ff @(posedge clk) begin
        if (rst) begin
            predFailed   <= `FALSE;
            waitDs       <= `FALSE;
            lastWaitDs   <= `FALSE;
            excValid     <= `FALSE;
            commitValid0 <= `FALSE;
            commitValid1 <= `FALSE;
            wrRegCommit0 <= `FALSE;
            wrRegCommit1 <= `FALSE;
        end else begin
            predFailed   <= predFailNow;
            waitDs       <= predFailNow && headUop1.kind == uopBubble;  // Delay slot not here yet.
            lastWaitDs   <= waitDs && !flush;
            excValid     <= pop && (exc0 || exc1);
            commitValid0 <= pop && headUop0.valid;
            commitValid1 <= pop && headUop1.valid;
            wrRegCommit0 <= pop && headUop0.valid && headUop0.dstwe;
            wrRegCommit1 <= pop && headUop1.valid && headUop1.dstwe;
        end
    end

    always_ff @(posedge clk) begin
        if (predFailNow) begin
            branchTarget <= target;                 // Held across the delay-slot wait.
        end
        excKind       <= exc1 ? headUop1.payload.exc.kind : headUop0.payload.exc.kind;
        excCode       <= exc1 ? headUop1.payload.exc.code : headUop0.payload.exc.code;
        committedArf0 <= headUop0.dstLAddr;
        committedArf1 <= headUop1.dstLAddr;
        committedPrf0 <= headUop0.dstPAddr;
        committedPrf1 <= headUop1.dstPAddr;
        stalePrf0     <= headUop0.dstPStale;
        stalePrf1     <= headUop1.dstPStale;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Flush and redirect, exception first
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        if (excValid) begin
            redirect   = `TRUE;
            redirectPc = `EXC_VECTOR;
        end else if ((predFailed && !waitDs) || lastWaitDs) begin
            redirect   = `TRUE;
            redirectPc = branchTarget;
        end else begin
            redirect   = `FALSE;
            redirectPc = '0;
        end
    end

    assign flush = redirect;

endmodule

// ==== verilog/committedMapTable.sv ====
`timescale 1ns/1ns
`include "commit_defines.svh"

module committedMapTable (
    input  logic                clk,
    input  logic                rst,

    input  logic                commitValid0,
    input  logic                commitValid1,
    input  logic                wrRegCommit0,
    input  logic                wrRegCommit1,
    input  logic [`ARF_W-1:0]   committedArf0,
    input  logic [`ARF_W-1:0]   committedArf1,
    input  logic [`PRF_W-1:0]   committedPrf0,
    input  logic [`PRF_W-1:0]   committedPrf1,
    input  logic [`PRF_W-1:0]   stalePrf0,
    input  logic [`PRF_W-1:0]   stalePrf1,

    input  logic [`ARF_W-1:0]   lookupArf,
    output logic [`PRF_W-1:0]   lookupPrf,

    output logic                freeValid0,
    output logic                freeValid1,
    output logic [`PRF_W-1:0]   freePrf0,
    output logic [`PRF_W-1:0]   freePrf1
);

    localparam int ARF_N = 1 << `ARF_W;

    logic [`PRF_W-1:0]  mapTable [ARF_N];
    logic               write0;
    logic               write1;

    assign write0 = commitValid0 && wrRegCommit0;
    assign write1 = commitValid1 && wrRegCommit1;

    assign lookupPrf = mapTable[lookupArf];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ARF_N; i++) begin
                mapTable[i] <= `PRF_W'(i % `PRF_N);    // Identity map out of reset.
            end
            freeValid0 <= `FALSE;
            freeValid1 <= `FALSE;
        end else begin
            if (write0) begin
                mapTable[committedArf0] <= committedPrf0;
            end
            if (write1) begin
                mapTable[committedArf1] <= committedPrf1;   // Younger slot wins on same ARF.
            end
            freeValid0 <= write0;
            freeValid1 <= write1;
        end
    end

    always_ff @(posedge clk) begin
        freePrf0 <= stalePrf0;
        freePrf1 <= stalePrf1;
    end

endmodule

// ==== verilog/commitTop.sv ====
`timescale 1ns/1ns
`include "commit_defines.svh"

module commitTop (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    pushValid,
    input  uopPkg::RetiredUop       pushUop0,
    input  uopPkg::RetiredUop       pushUop1,
    output logic                    queueFull,

    output logic                    flush,
    output logic                    redirect,
    output logic [`ADDR_W-1:0]      redirectPc,

    output logic                    excValid,
    output excPkg::ExceptionType    excKind,
    output logic [`EXC_CODE_W-1:0]  excCode,

    output logic                    commitValid0,
    output logic                    commitValid1,
    output logic                    wrRegCommit0,
    output logic                    wrRegCommit1,
    output logic [`ARF_W-1:0]       committedArf0,
    output logic [`ARF_W-1:0]       committedArf1,
    output logic [`PRF_W-1:0]       committedPrf0,
    output logic [`PRF_W-1:0]       committedPrf1,

    output logic                    freeValid0,
    output logic                    freeValid1,
    output logic [`PRF_W-1:0]       freePrf0,
    output logic [`PRF_W-1:0]       freePrf1,

    input  logic [`ARF_W-1:0]       lookupArf,
    output logic [`PRF_W-1:0]       lookupPrf
);

    import uopPkg::*;

    logic               headValid;
    RetiredUop          headUop0;
    RetiredUop          headUop1;
    logic               pop;
    logic [`PRF_W-1:0]  stalePrf0;
    logic [`PRF_W-1:0]  stalePrf1;

    completionQueue completionQueue_i (
        .clk        (clk),
        .rst        (rst),
        .pushValid  (pushValid),
        .pushUop0   (pushUop0),
        .pushUop1   (pushUop1),
        .pop        (pop),
        .flush      (flush),
        .queueFull  (queueFull),
        .headValid  (headValid),
        .headUop0   (headUop0),
        .headUop1   (headUop1)
    );

    commitStage commitStage_i (
        .clk            (clk),
        .rst            (rst),
        .headValid      (headValid),
        .headUop0       (headUop0),
        .headUop1       (headUop1),
        .pop            (pop),
        .commitValid0   (commitValid0),
        .commitValid1   (commitValid1),
        .wrRegCommit0   (wrRegCommit0),
        .wrRegCommit1   (wrRegCommit1),
        .committedArf0  (committedArf0),
        .committedArf1  (committedArf1),
        .committedPrf0  (committedPrf0),
        .committedPrf1  (committedPrf1),
        .stalePrf0      (stalePrf0),
        .stalePrf1      (stalePrf1),
        .flush          (flush),
        .redirect       (redirect),
        .redirectPc     (redirectPc),
        .excValid       (excValid),
        .excKind        (excKind),
        .excCode        (excCode)
    );

    committedMapTable committedMapTable_i (
        .clk            (clk),
        .rst            (rst),
        .commitValid0   (commitValid0),
        .commitValid1   (commitValid1),
        .wrRegCommit0   (wrRegCommit0),
        .wrRegCommit1   (wrRegCommit1),
        .committedArf0  (committedArf0),
        .committedArf1  (committedArf1),
        .committedPrf0  (committedPrf0),
        .committedPrf1  (committedPrf1),
        .stalePrf0      (stalePrf0),
        .stalePrf1      (stalePrf1),
        .lookupArf      (lookupArf),
        .lookupPrf      (lookupPrf),
        .freeValid0     (freeValid0),
        .freeValid1     (freeValid1),
        .freePrf0       (freePrf0),
        .freePrf1       (freePrf1)
    );

endmodule

// ==== tb/commitTb.sv ====
`timescale 1ns/1ns
`include "commit_defines.svh"

module commitTb;

    import uopPkg::*;
    import excPkg::*;

    localparam int NROWS = 10;
    localparam int BURST = 8;
    localparam int WATCHDOG_CYCLES = (NROWS + BURST) * 4 + 50;

    logic                   clk;
    logic                   rst;
    logic                   pushValid;
    RetiredUop              pushUop0;
    RetiredUop              pushUop1;
    logic                   queueFull;
    logic                   flush;
    logic                   redirect;
    logic [`ADDR_W-1:0]     redirectPc;
    logic                   excValid;
    ExceptionType           excKind;
    logic [`EXC_CODE_W-1:0] excCode;
    logic                   commitValid0;
    logic                   commitValid1;
    logic                   wrRegCommit0;
    logic                   wrRegCommit1;
    logic [`ARF_W-1:0]      committedArf0;
    logic [`ARF_W-1:0]      committedArf1;
    logic [`PRF_W-1:0]      committedPrf0;
    logic [`PRF_W-1:0]      committedPrf1;
    logic                   freeValid0;
    logic                   freeValid1;
    logic [`PRF_W-1:0]      freePrf0;
    logic [`PRF_W-1:0]      freePrf1;
    logic [`ARF_W-1:0]      lookupArf;
    logic [`PRF_W-1:0]      lookupPrf;

    // Stimulus table, one retiring pair per row.
    RetiredUop              rowUop0 [NROWS];
    RetiredUop              rowUop1 [NROWS];
    logic                   rowRedir [NROWS];
    logic                   rowDelay [NROWS];      // Redirect waits for the delay slot.
    logic [31:0]            rowPc [NROWS];
    logic                   rowExc [NROWS];
    ExceptionType           rowKind [NROWS];
    logic [19:0]            rowCode [NROWS];
    logic                   rowTrailer [NROWS];    // Younger pair pushed behind the row.

    logic [`PRF_W-1:0]      refMap [32];
    logic [31:0]            lcgState;
    int                     errCount;
    logic [37:0]            expQ [$];
    logic [13:0]            freeQ [$];
    logic                   burstStarted;

    commitTop commitTop_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * 100);
        $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("Test FAILED");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks and stimulus helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic checkVal(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else begin
            errCount++;
            $display("MISMATCH %s got=%h exp=%h", name, got, exp);
        end
    endtask

    task automatic checkPulse(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            errCount++;
            if (exp) $display("%s pulse missing at time %0t", name, $time);
            else $display("%s pulse not expected at time %0t", name, $time);
        end
    endtask

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic RetiredUop makeAlu(input logic [31:0] pc);
        RetiredUop u;
        logic [31:0] r;
        r = nextRand();
        u = '0;
        u.valid = 1'b1;
        u.kind = uopAlu;
        u.pc = pc;
        u.branchType = typeNormal;
        u.dstwe = 1'b1;
        u.dstLAddr = r[20:16];
        u.dstPAddr = r[30:24];
        return u;
    endfunction

    function automatic RetiredUop makeBranch(input logic [31:0] pc, input logic taken,
                                             input logic pred, input logic [31:0] addr,
                                             input logic [31:0] predAddr);
        RetiredUop u;
        u = '0;
        u.valid = 1'b1;
        u.kind = uopBranch;
        u.pc = pc;
        u.branchType = typeBranch;
        u.branchTaken = taken;
        u.predTaken = pred;
        u.predAddr = predAddr;
        u.payload.branchAddr = addr;
        return u;
    endfunction

    function automatic RetiredUop makeExc(input logic [31:0] pc, input ExceptionType k,
                                          input logic [19:0] code);
        RetiredUop u;
        u = '0;
        u.valid = 1'b1;
        u.kind = uopAlu;
        u.pc = pc;
        u.causeExc = 1'b1;
        u.payload.exc.kind = k;
        u.payload.exc.code = code;
        return u;
    endfunction

    task automatic setRow(input int i, input RetiredUop u0, input RetiredUop u1,
                          input logic redir, input logic delay, input logic [31:0] pc,
                          input logic exc, input ExceptionType k, input logic [19:0] code,
                          input logic trailer);
        rowUop0[i] = u0;
        rowUop1[i] = u1;
        rowRedir[i] = redir;
        rowDelay[i] = delay;
        rowPc[i] = pc;
        rowExc[i] = exc;
        rowKind[i] = k;
        rowCode[i] = code;
        rowTrailer[i] = trailer;
    endtask

    task automatic buildTable();
        RetiredUop same0;
        RetiredUop same1;
        RetiredUop bubble;
        bubble = '0;
        bubble.kind = uopBubble;
        same0 = makeAlu(32'h1010);
        same1 = makeAlu(32'h1014);
        same0.dstLAddr = 5'd7;                      // Both slots write r7.
        same1.dstLAddr = 5'd7;
        setRow(0, makeAlu(32'h1000), makeAlu(32'h1004), 0, 0, 0, 0, excNone, 0, 0);
        setRow(1, same0, same1, 0, 0, 0, 0, excNone, 0, 0);
        setRow(2, makeBranch(32'h1020, 1, 1, 32'h2000, 32'h2000), makeAlu(32'h1024),
               0, 0, 0, 0, excNone, 0, 0);
        setRow(3, makeBranch(32'h2000, 0, 0, 32'h3000, 32'h0), makeAlu(32'h2004),
               0, 0, 0, 0, excNone, 0, 0);
        setRow(4, makeBranch(32'h2010, 1, 0, 32'h4000, 32'h0), makeAlu(32'h2014),
               1, 0, 32'h4000, 0, excNone, 0, 1);
        setRow(5, makeBranch(32'h4000, 0, 1, 32'h5000, 32'h5000), makeAlu(32'h4004),
               1, 0, 32'h4008, 0, excNone, 0, 1);
        setRow(6, makeBranch(32'h4010, 1, 1, 32'h6000, 32'h6600), bubble,
               1, 1, 32'h6000, 0, excNone, 0, 0);
        setRow(7, makeExc(32'h6000, excSyscall, 20'h12345), makeAlu(32'h6004),
               1, 0, `EXC_VECTOR, 1, excSyscall, 20'h12345, 0);
        setRow(8, makeAlu(32'h6010), makeExc(32'h6014, excOverflow, 20'h0abcd),
               1, 0, `EXC_VECTOR, 1, excOverflow, 20'h0abcd, 0);
        setRow(9, makeExc(32'h7000, excBreak, 20'h11111), makeExc(32'h7004, excAddrLoad, 20'h22222),
               1, 0, `EXC_VECTOR, 1, excAddrLoad, 20'h22222, 0);
    endtask

    // Rename stale registers come from the reference map, oldest slot first.
    task automatic renamePair(inout RetiredUop u0, inout RetiredUop u1);
        u0.dstPStale = refMap[u0.dstLAddr];
        if (u0.valid && u0.dstwe) refMap[u0.dstLAddr] = u0.dstPAddr;
        u1.dstPStale = refMap[u1.dstLAddr];
        if (u1.valid && u1.dstwe) refMap[u1.dstLAddr] = u1.dstPAddr;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Single pair with full timing checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic applyRow(input int i);
        RetiredUop u0;
        RetiredUop u1;
        logic w0;
        logic w1;
        int waitCnt;
        u0 = rowUop0[i];
        u1 = rowUop1[i];
        w0 = u0.valid && u0.dstwe;
        w1 = u1.valid && u1.dstwe;
        renamePair(u0, u1);
        @(posedge clk);
        #5;
        pushValid = 1'b1;
        pushUop0 = u0;
        pushUop1 = u1;
        lookupArf = u1.dstLAddr;
        @(posedge clk);
        #5;
        pushValid = rowTrailer[i];                  // Younger pair must be discarded.
        pushUop0 = makeAlu(32'h9000);
        pushUop1 = makeAlu(32'h9004);
        @(posedge clk);
        #5;
        pushValid = 1'b0;
        waitCnt = 0;
        do begin
            @(negedge clk);
            waitCnt++;
        end while (!(commitValid0 || commitValid1) && waitCnt < 8);
        assert (commitValid0 || commitValid1) else begin
            errCount++;
            $display("Row %0d never committed", i);
        end
        checkPulse("commitValid0", commitValid0, u0.valid);
        checkPulse("commitValid1", commitValid1, u1.valid);
        checkPulse("wrRegCommit0", wrRegCommit0, w0);
        checkPulse("wrRegCommit1", wrRegCommit1, w1);
        if (w0) checkVal("committedArf0", 64'(committedArf0), 64'(u0.dstLAddr));
        if (w0) checkVal("committedPrf0", 64'(committedPrf0), 64'(u0.dstPAddr));
        if (w1) checkVal("committedArf1", 64'(committedArf1), 64'(u1.dstLAddr));
        if (w1) checkVal("committedPrf1", 64'(committedPrf1), 64'(u1.dstPAddr));
        checkPulse("excValid", excValid, rowExc[i]);
        if (rowExc[i]) checkVal("excKind", 64'(excKind), 64'(rowKind[i]));
        if (rowExc[i]) checkVal("excCode", 64'(excCode), 64'(rowCode[i]));
        checkPulse("redirect", redirect, rowRedir[i] && !rowDelay[i]);
        checkPulse("flush", flush, rowRedir[i] && !rowDelay[i]);
        if (rowRedir[i] && !rowDelay[i]) checkVal("redirectPc", 64'(redirectPc), 64'(rowPc[i]));
        @(negedge clk);
        checkPulse("freeValid0", freeValid0, w0);
        checkPulse("freeValid1", freeValid1, w1);
        if (w0) checkVal("freePrf0", 64'(freePrf0), 64'(u0.dstPStale));
        if (w1) checkVal("freePrf1", 64'(freePrf1), 64'(u1.dstPStale));
        checkVal("lookupPrf", 64'(lookupPrf), 64'(refMap[u1.dstLAddr]));
        checkPulse("redirect", redirect, rowRedir[i] && rowDelay[i]);
        if (rowRedir[i] && rowDelay[i]) checkVal("redirectPc", 64'(redirectPc), 64'(rowPc[i]));
        checkPulse("excValid", excValid, 1'b0);
        checkPulse("commitValid0", commitValid0, 1'b0);
        repeat (3) begin
            @(negedge clk);
            checkPulse("commitValid0", commitValid0, 1'b0);
            checkPulse("redirect", redirect, 1'b0);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Back-to-back random pairs
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic observeBurst();
        logic [37:0] e;
        logic [13:0] f;
        checkPulse("redirect", redirect, 1'b0);
        checkPulse("queueFull", queueFull, 1'b0);  // One pop per push keeps it shallow.
        if (freeQ.size() > 0) begin
            f = freeQ.pop_front();
            checkPulse("freeValid0", freeValid0, 1'b1);
            checkPulse("freeValid1", freeValid1, 1'b1);
            checkVal("freePrf0", 64'(freePrf0), 64'(f[13:7]));
            checkVal("freePrf1", 64'(freePrf1), 64'(f[6:0]));
        end
        if (commitValid0) begin
            burstStarted = 1'b1;
            if (expQ.size() == 0) begin
                errCount++;
                $display("Commit seen with no pair outstanding");
            end else begin
                e = expQ.pop_front();
                checkVal("committed", 64'({committedArf0, committedPrf0, committedArf1,
                                           committedPrf1}), 64'(e[37:14]));
                freeQ.push_back(e[13:0]);
            end
        end else if (burstStarted && expQ.size() > 0) begin
            errCount++;
            $display("Retire gap in back-to-back pairs at time %0t", $time);
        end
    endtask

    task automatic runBurst();
        RetiredUop u0;
        RetiredUop u1;
        int cycles;
        burstStarted = 1'b0;
        for (int k = 0; k < BURST; k++) begin
            u0 = makeAlu(32'h8000 + 32'(k * 8));
            u1 = makeAlu(32'h8004 + 32'(k * 8));
            renamePair(u0, u1);
            expQ.push_back({u0.dstLAddr, u0.dstPAddr, u1.dstLAddr, u1.dstPAddr,
                            u0.dstPStale, u1.dstPStale});
            @(posedge clk);
            #5;
            pushValid = 1'b1;
            pushUop0 = u0;
            pushUop1 = u1;
            @(negedge clk);
            observeBurst();
        end
        @(posedge clk);
        #5;
        pushValid = 1'b0;
        cycles = 0;
        while ((expQ.size() > 0 || freeQ.size() > 0) && cycles < 20) begin
            @(negedge clk);
            observeBurst();
            cycles++;
        end
        assert (expQ.size() == 0 && freeQ.size() == 0) else begin
            errCount++;
            $display("Burst pairs still outstanding at the end");
        end
    endtask

    initial begin
        rst = 1'b1;
        pushValid = 1'b0;
        pushUop0 = '0;
        pushUop1 = '0;
        lookupArf = '0;
        errCount = 0;
        lcgState = 32'h824a276c;
        for (int i = 0; i < 32; i++) refMap[i] = `PRF_W'(i);
        buildTable();
        repeat (8) @(posedge clk);
        #5;
        rst = 1'b0;
        @(negedge clk);
        checkPulse("flush", flush, 1'b0);
        checkPulse("excValid", excValid, 1'b0);
        checkPulse("commitValid0", commitValid0, 1'b0);
        checkPulse("freeValid0", freeValid0, 1'b0);
        for (int i = 0; i < NROWS; i++) applyRow(i);
        runBurst();
        $display("Errors: %0d", errCount);
        if (errCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+include
verilog/excPkg.sv
verilog/uopPkg.sv
verilog/completionQueue.sv
verilog/commitStage.sv
verilog/committedMapTable.sv
verilog/commitTop.sv
tb/commitTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the commit testbench with Verilator.
rm -f sim.log
verilator --binary -f tb.f --top-module commitTb -Mdir obj_dir -o simv \
    && ./obj_dir/simv | tee sim.log \
    || echo "Test FAILED" >> sim.log
grep -q "Test FAILED" sim.log && exit 1 || exit 0
